// ==== build.f ====
verilog/fetch_pkg.sv
verilog/branch_predictor.sv
verilog/instr_mem.sv
verilog/fetch.sv
verilog/fetch_top.sv
verif/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/branch_predictor.sv
      - verilog/instr_mem.sv
      - verilog/fetch.sv
      - verilog/fetch_top.sv
  - target: test
    files:
      - verif/fetch_tb.sv

// ==== verif/fetch_tb.sv ====
// ==========================================================================
// Testbench for the fetch stage. Each table row loads a program while
// halted, resets, trains the predictor and collects packets. Redirects
// carry is_branch low, so the trained counter stays where training left it.
// ==========================================================================

module fetch_tb;

    localparam int               MEM_WORDS    = 256;
    localparam int               MISS_LATENCY = 4;
    localparam fetch_pkg::addr_t RESET_PC     = 16'h0000;
    localparam int               NUM_TESTS    = 9;
    localparam int               HALT_CYCLES  = 12;       // Covers one miss plus stalls
    localparam int               RAND_SEED    = 57139;
    localparam int               NONE         = 255;      // No redirect or halt in row

    // One row of the test table
    typedef struct packed {
        logic [1:0]  kind;          // 0 straight, 1 loop, 2 spread
        logic [7:0]  ready_pct;     // Chance of out_ready per cycle
        logic [7:0]  redir_idx;     // Redirect after this packet
        logic [15:0] redir_target;
        logic [2:0]  train;         // Taken resolves before fetch starts
        logic [7:0]  halt_idx;      // Halt after this packet
        logic [7:0]  npkts;
    } test_row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    fetch_pkg::load_t      load;
    logic                  load_valid;
    logic                  halt;
    fetch_pkg::fetch_pkt_t out_pkt;
    logic                  out_valid;
    logic                  out_ready;
    fetch_pkg::resolve_t   resolve;
    logic                  resolve_valid;

    test_row_t         tests [NUM_TESTS];
    fetch_pkg::instr_t image [MEM_WORDS];   // Reference copy of the program
    logic [1:0]        ref_ctr;             // Reference predictor counter
    int                errors;
    int                checks;
    int                watchdog_cycles;

    fetch_top #(
        .MEM_WORDS    (MEM_WORDS),
        .MISS_LATENCY (MISS_LATENCY),
        .RESET_PC     (RESET_PC)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .load_valid    (load_valid),
        .halt          (halt),
        .out_pkt       (out_pkt),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .resolve       (resolve),
        .resolve_valid (resolve_valid)
    );

    always #4 clk = ~clk;

    function automatic test_row_t make_row(int kind, int pct, int ridx, int rtgt,
                                           int train, int hidx, int n);
        test_row_t r;
        r.kind         = 2'(kind);
        r.ready_pct    = 8'(pct);
        r.redir_idx    = 8'(ridx);
        r.redir_target = 16'(rtgt);
        r.train        = 3'(train);
        r.halt_idx     = 8'(hidx);
        r.npkts        = 8'(n);
        return r;
    endfunction

    // Plain words never carry opcode 011
    function automatic fetch_pkg::instr_t program_word(logic [1:0] kind, int idx);
        fetch_pkg::instr_t w;
        w = {3'b001, 13'(idx * 37 + 5)};
        if (kind == 2'd1 && idx % 8 == 5)
            w = 16'h60F4;                           // Back to start of the 16-byte block
        else if (kind == 2'd2 && idx % 3 == 2)
            w = {8'h60, 8'(4 + 2 * (idx % 4))};     // Forward hop across lines
        return w;
    endfunction

    // Next packet along the predicted path
    function automatic fetch_pkg::fetch_pkt_t expected_pkt(fetch_pkg::addr_t pc);
        fetch_pkg::fetch_pkt_t p;
        logic                  br;
        fetch_pkg::addr_t      offset;
        p.instr      = image[int'(pc >> 1) % MEM_WORDS];
        br           = (p.instr[15:13] == 3'b011);
        offset       = {{8{p.instr[7]}}, p.instr[7:0]};
        p.pc         = pc;
        p.pred_taken = br && ref_ctr[1];
        p.pc_next    = p.pred_taken ? pc + 16'd2 + offset : pc + 16'd2;
        return p;
    endfunction

    task automatic compare_value(string name, logic [63:0] exp, logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic load_program(logic [1:0] kind);
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            image[i]   = program_word(kind, i);
            load.addr  = 15'(i);
            load.data  = image[i];
            load_valid = 1'b1;
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("out_valid", 64'd0, {63'd0, out_valid});   // Nothing out of reset
    endtask

    // Taken resolves one per cycle with the reference counter alongside
    task automatic train_predictor(int n);
        ref_ctr = 2'd1;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            resolve_valid        = 1'b1;
            resolve.is_branch    = 1'b1;
            resolve.taken        = 1'b1;
            resolve.mispredict   = 1'b0;
            resolve.target       = '0;
            if (ref_ctr != 2'd3)
                ref_ctr = ref_ctr + 2'd1;
        end
        @(negedge clk);
        resolve_valid = 1'b0;
        resolve       = '0;
    endtask

    task automatic run_test(int t);
        test_row_t             row;
        fetch_pkg::addr_t      exp_pc;
        fetch_pkg::fetch_pkt_t exp;
        fetch_pkg::fetch_pkt_t held;
        logic                  fire;
        logic                  stalled;
        int                    got;
        int                    halt_left;
        int                    halt_fires;
        int                    err_before;
        row        = tests[t];
        err_before = errors;
        halt       = 1'b1;
        out_ready  = 1'b0;
        load_program(row.kind);
        pulse_reset();
        train_predictor(row.train);
        @(negedge clk);
        halt       = 1'b0;
        exp_pc     = RESET_PC;
        got        = 0;
        halt_left  = 0;
        halt_fires = 0;
        while (got < row.npkts) begin
            // What was set up at this negedge meets the DUT at the next posedge
            fire    = out_valid && out_ready;
            stalled = out_valid && !out_ready && !(resolve_valid && resolve.mispredict);
            held    = out_pkt;
            @(negedge clk);
            resolve_valid = 1'b0;
            if (stalled) begin
                compare_value("out_valid", 64'd1, {63'd0, out_valid});
                compare_value("out_pkt", held, out_pkt);      // Held while stalled
            end
            if (halt_left > 0) begin
                halt_fires += int'(fire);
                halt_left--;
                if (halt_left == 0) begin
                    checks++;
                    assert (halt_fires <= 1) else begin
                        $display("FAILED t=%0t out_valid transfers under halt exp<=1 got=%0d",
                                 $time, halt_fires);
                        errors++;
                    end
                    if (halt_fires == 1)
                        compare_value("out_valid", 64'd0, {63'd0, out_valid});
                    halt = 1'b0;
                end
            end
            if (fire) begin
                exp = expected_pkt(exp_pc);
                compare_value("out_pkt.pc", exp.pc, held.pc);
                compare_value("out_pkt.instr", exp.instr, held.instr);
                compare_value("out_pkt.pc_next", exp.pc_next, held.pc_next);
                compare_value("out_pkt.pred_taken", exp.pred_taken, held.pred_taken);
                exp_pc = exp.pc_next;
                if (got == row.redir_idx) begin
                    resolve_valid      = 1'b1;
                    resolve.is_branch  = 1'b0;
                    resolve.taken      = 1'b0;
                    resolve.mispredict = 1'b1;
                    resolve.target     = row.redir_target;
                    exp_pc             = row.redir_target;   // Squashed path must vanish
                end
                if (got == row.halt_idx) begin
                    halt       = 1'b1;
                    halt_left  = HALT_CYCLES;
                    halt_fires = 0;
                end
                got++;
            end
            out_ready = ($urandom % 100) < row.ready_pct;
        end
        // Freeze and let any outstanding response land
        halt      = 1'b1;
        out_ready = 1'b0;
        @(negedge clk);
        resolve_valid = 1'b0;
        resolve       = '0;
        repeat (MISS_LATENCY + 3) @(negedge clk);
        $display("test %0d kind %0d: %0d packets, %0d errors", t, row.kind, got,
                 errors - err_before);
    endtask

    initial begin
        int seed_ret;
        int total;
        seed_ret      = $urandom(RAND_SEED);
        rst_n         = 1'b0;
        load          = '0;
        load_valid    = 1'b0;
        halt          = 1'b1;
        out_ready     = 1'b0;
        resolve       = '0;
        resolve_valid = 1'b0;
        errors        = 0;
        checks        = 0;
        ref_ctr       = 2'd1;
        //                   kind pct  redir  target train halt  pkts
        tests[0] = make_row(0, 100, NONE, 0,     0, NONE, 24);   // Sequential stream
        tests[1] = make_row(0,  40, NONE, 0,     0, NONE, 32);   // Back-pressure
        tests[2] = make_row(1, 100, NONE, 0,     2, NONE, 30);   // Trained loop taken
        tests[3] = make_row(1, 100, NONE, 0,     0, NONE, 20);   // Weak NT falls through
        tests[4] = make_row(1,  60, 7,    'h40,  3, NONE, 24);   // Mispredict redirect
        tests[5] = make_row(2, 100, NONE, 0,     2, NONE, 30);   // Hops across lines
        tests[6] = make_row(2,  35, NONE, 0,     0, NONE, 30);
        tests[7] = make_row(0,  70, NONE, 0,     0, 9,    28);   // Halt mid-stream
        tests[8] = make_row(2,  50, 11,   'h102, 2, 4,    30);
        total = 0;
        for (int i = 0; i < NUM_TESTS; i++)
            total += int'(tests[i].npkts);
        watchdog_cycles = (MISS_LATENCY + 2) * 4 * total
                        + NUM_TESTS * (MEM_WORDS + 64 + HALT_CYCLES);
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests=%0d checks=%0d errors=%0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Budget covers program loading plus the slowest packet rate
    initial begin
        #1;
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: packets stopped arriving within %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== verilog/fetch_top.sv ====
// ==========================================================================
// Fetch stage top. Parameters are set here and passed to the leaves.
// Output latency varies with line-buffer hits and misses.
// ==========================================================================

module fetch_top #(
    parameter int               MEM_WORDS    = 256,
    parameter int               MISS_LATENCY = 4,
    parameter fetch_pkg::addr_t RESET_PC     = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::load_t      load,
    input  logic                  load_valid,
    input  logic                  halt,
    output fetch_pkg::fetch_pkt_t out_pkt,
    output logic                  out_valid,
    input  logic                  out_ready,
    input  fetch_pkg::resolve_t   resolve,
    input  logic                  resolve_valid
);

    fetch_pkg::addr_t  req_addr;   // Fetch to memory
    logic              req_valid;
    logic              req_ready;
    fetch_pkg::instr_t rsp_instr;  // Memory back to fetch
    logic              rsp_valid;
    logic              predict_taken;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk, .rst_n, .halt,
        .req_addr, .req_valid, .req_ready,
        .rsp_instr, .rsp_valid,
        .predict_taken,
        .resolve, .resolve_valid,
        .out_pkt, .out_valid, .out_ready
    );

    instr_mem #(
        .MEM_WORDS    (MEM_WORDS),
        .MISS_LATENCY (MISS_LATENCY)
    ) u_instr_mem (
        .clk, .rst_n, .load, .load_valid,
        .req_addr, .req_valid, .req_ready,
        .rsp_instr, .rsp_valid
    );

    branch_predictor u_bp (
        .clk, .rst_n, .resolve, .resolve_valid, .predict_taken
    );

endmodule

// ==== verilog/fetch.sv ====
// ==========================================================================
// PC, request issue and output register toward decode. At most one
// request outstanding plus one buffered packet. A mispredict redirect
// wins over every other update; late responses are dropped via squash.
// ==========================================================================

module fetch #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  halt,
    output fetch_pkg::addr_t      req_addr,
    output logic                  req_valid,
    input  logic                  req_ready,
    input  fetch_pkg::instr_t     rsp_instr,
    input  logic                  rsp_valid,
    input  logic                  predict_taken,
    input  fetch_pkg::resolve_t   resolve,
    input  logic                  resolve_valid,
    output fetch_pkg::fetch_pkt_t out_pkt,
    output logic                  out_valid,
    input  logic                  out_ready
);

    fetch_pkg::addr_t      pc;            // Address of next or outstanding fetch
    logic                  pending;       // Request in memory
    logic                  squash;        // Drop that response on arrival
    fetch_pkg::fetch_pkt_t pkt_q;
    logic                  valid_q;

    logic                  flush;
    logic                  room;
    logic                  req_fire;
    logic                  rsp_take;
    logic                  taken;
    fetch_pkg::addr_t      pc_seq;
    fetch_pkg::addr_t      pc_pred;
    fetch_pkg::fetch_pkt_t new_pkt;

    assign flush    = resolve_valid && resolve.mispredict;
    assign room     = !valid_q || out_ready;          // Empty, or draining now
    assign req_fire = req_valid && req_ready;
    assign rsp_take = rsp_valid && !squash;

    // Issue only with space for the result, halt blocks new requests
    assign req_valid = !pending && !halt && room;
    assign req_addr  = pc;

    // Next-PC selection from the returned word
    assign taken   = fetch_pkg::is_branch(rsp_instr) && predict_taken;
    assign pc_seq  = pc + fetch_pkg::addr_t'(2);
    assign pc_pred = taken ? fetch_pkg::branch_target(pc, rsp_instr) : pc_seq;

    always_comb begin
        new_pkt.instr      = rsp_instr;
        new_pkt.pc         = pc;                // Unchanged since issue
        new_pkt.pc_next    = pc_pred;
        new_pkt.pred_taken = taken;
    end

    // PC and request bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            pending <= 1'b0;
            squash  <= 1'b0;
        end else begin
            // req_fire and rsp_valid never coincide, one in flight
            if (req_fire)
                pending <= 1'b1;
            else if (rsp_valid)
                pending <= 1'b0;

            if (flush) begin
                pc     <= resolve.target;
                // Anything still in memory after this edge is stale
                squash <= (pending && !rsp_valid) || req_fire;
            end else begin
                if (rsp_valid)
                    squash <= 1'b0;
                if (rsp_take)
                    pc <= pc_pred;              // Advance along predicted path
            end
        end
    end

    // Output register toward decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q            <= 1'b0;
            pkt_q.instr        <= fetch_pkg::NOP_INSTR;
            pkt_q.pc           <= RESET_PC;
            pkt_q.pc_next      <= RESET_PC;
            pkt_q.pred_taken   <= 1'b0;
        end else if (flush) begin
            valid_q            <= 1'b0;        // Wrong-path packet dies
            pkt_q.instr        <= fetch_pkg::NOP_INSTR;
            pkt_q.pred_taken   <= 1'b0;
        end else if (rsp_take) begin
            valid_q <= 1'b1;
            pkt_q   <= new_pkt;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign out_pkt   = pkt_q;
    assign out_valid = valid_q;

    // Stalled packet holds until taken, unless execute redirects
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_pkt))
    );

    // Memory must be idle whenever fetch issues, so no second request
    // starts while one is pending there
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> req_ready
    );

    // A response only comes back for something fetch asked for
    a_rsp_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> pending
    );

endmodule

// ==== verilog/instr_mem.sv ====
// ==========================================================================
// Instruction memory with a one-line buffer that only models timing.
// MEM_WORDS must be a power of two, MISS_LATENCY at least 1. Loads are
// expected while fetch is halted; the response is always taken.
// ==========================================================================

module instr_mem #(
    parameter int MEM_WORDS    = 256,
    parameter int MISS_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  fetch_pkg::load_t  load,
    input  logic              load_valid,
    input  fetch_pkg::addr_t  req_addr,
    input  logic              req_valid,
    output logic              req_ready,
    output fetch_pkg::instr_t rsp_instr,
    output logic              rsp_valid
);

    localparam int LINE_WORDS = 4;                              // Words per buffer line
    localparam int OFF_W      = $clog2(LINE_WORDS * 2);         // Byte offset inside a line
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int CNT_W      = (MISS_LATENCY > 1) ? $clog2(MISS_LATENCY) : 1;

    typedef enum logic [1:0] {IDLE, WAIT, RESPOND} state_t;

    fetch_pkg::instr_t mem [MEM_WORDS];

    state_t                state;
    logic [CNT_W-1:0]      cnt;           // Miss countdown
    logic [15-OFF_W:0]     line_tag;      // Line currently buffered
    logic                  line_valid;
    logic [15-OFF_W:0]     miss_tag;      // Tag of the outstanding miss
    fetch_pkg::instr_t     data_q;        // Word read at acceptance
    logic                  req_fire;
    logic                  hit;
    logic [IDX_W-1:0]      req_idx;

    assign req_idx  = req_addr[IDX_W:1];
    assign req_fire = req_valid && req_ready;
    assign hit      = line_valid && (line_tag == req_addr[15:OFF_W]);

    // Load port, testbench fills the image
    always_ff @(posedge clk) begin
        if (load_valid)
            mem[load.addr[IDX_W-1:0]] <= load.data;
    end

    // Word and tag are captured when the request is taken
    always_ff @(posedge clk) begin
        if (req_fire) begin
            data_q   <= mem[req_idx];
            miss_tag <= req_addr[15:OFF_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cnt        <= '0;
            line_tag   <= '0;
            line_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        if (hit) begin
                            state <= RESPOND;       // hit skips the wait
                        end else begin
                            state <= WAIT;
                            cnt   <= CNT_W'(MISS_LATENCY - 1);
                        end
                    end
                end
                WAIT: begin
                    if (cnt == '0) begin
                        state      <= RESPOND;
                        line_tag   <= miss_tag;     // Refill the buffer
                        line_valid <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RESPOND: state <= IDLE;             // Consumer never stalls
                default: state <= IDLE;
            endcase
        end
    end

    assign req_ready = (state == IDLE);   // One request at a time
    assign rsp_valid = (state == RESPOND);
    assign rsp_instr = data_q;

    a_req_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> (req_addr[0] == 1'b0)
    );

endmodule

// ==== verilog/branch_predictor.sv ====
// ==========================================================================
// Single global 2-bit saturating counter shared by every branch.
// Trained only by resolutions flagged is_branch; no per-PC history.
// ==========================================================================

module branch_predictor (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::resolve_t resolve,
    input  logic                resolve_valid,
    output logic                predict_taken
);

    // Counter encodings
    localparam logic [1:0] STRONG_NT = 2'd0;
    localparam logic [1:0] WEAK_NT   = 2'd1;   // reset state
    localparam logic [1:0] STRONG_T  = 2'd3;

    logic [1:0] ctr;
    logic       train;      // a branch resolved this cycle
    logic       inc_ok;     // Room to count up
    logic       dec_ok;     // Room to count down

    assign train  = resolve_valid && resolve.is_branch;
    assign inc_ok = ctr != STRONG_T;
    assign dec_ok = ctr != STRONG_NT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr <= WEAK_NT;
        end else if (train) begin
            if (resolve.taken) begin
                if (inc_ok)
                    ctr <= ctr + 2'd1;   // Saturate at 3
            end else begin
                if (dec_ok)
                    ctr <= ctr - 2'd1;   // Saturate at 0
            end
        end
    end

    // Upper bit says taken in states 2 and 3
    assign predict_taken = ctr[1];

endmodule

// ==== verilog/fetch_pkg.sv ====
// ==========================================================================
// Shared types for the fetch stage. 16-bit byte addresses, 16-bit words,
// so bit 0 of every fetch address is zero. Branch class is opcode 011.
// ==========================================================================

package fetch_pkg;

    typedef logic [15:0] addr_t;      // Byte address
    typedef logic [15:0] instr_t;     // One instruction word
    typedef logic [14:0] word_idx_t;  // Word index, used by the load port

    localparam logic [2:0] OPC_BRANCH = 3'b011;     // Conditional branch class
    localparam instr_t     NOP_INSTR  = 16'h0800;   // No-operation encoding

    // Packet handed to decode, 49 bits
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        addr_t  pc_next;     // Predicted next address
        logic   pred_taken;
    } fetch_pkt_t;

    // Resolution from execute, 19 bits
    typedef struct packed {
        logic  is_branch;
        logic  taken;
        logic  mispredict;
        addr_t target;       // Correct next address
    } resolve_t;

    // Memory load beat, 31 bits
    typedef struct packed {
        word_idx_t addr;
        instr_t    data;
    } load_t;

    function automatic logic is_branch(instr_t instr);
        return instr[15:13] == OPC_BRANCH;
    endfunction

    // Fall-through plus sign-extended low byte
    function automatic addr_t branch_target(addr_t pc, instr_t instr);
        return pc + addr_t'(2) + {{8{instr[7]}}, instr[7:0]};
    endfunction

endpackage
